// File: rtl/eth_cfg_pkg.sv
package eth_cfg_pkg;

  // field widths of the transmit stream
  localparam int DATA_W  = 64;
  localparam int IP_W    = 32;
  localparam int PORT_W  = 16;
  localparam int LEN_W   = 16;
  localparam int TTL_W   = 8;
  localparam int PROTO_W = 8;

  // one payload or header word
  typedef logic [DATA_W-1:0] data_word_t;

  typedef logic [IP_W-1:0]   ip_addr_t;
  typedef logic [PORT_W-1:0] udp_port_t;

  // length counted in 64-bit payload words
  typedef logic [LEN_W-1:0]  frame_len_t;

  typedef logic [TTL_W-1:0]  ttl_t;

  // ip protocol number for udp
  localparam logic [PROTO_W-1:0] UDP_PROTO = 8'd17;

endpackage

// File: rtl/tx_frame_pkg.sv
package tx_frame_pkg;

  // one committed frame, also sent as header word 0
  typedef struct packed {
    eth_cfg_pkg::ip_addr_t   dest_ip;
    eth_cfg_pkg::udp_port_t  dest_port;
    eth_cfg_pkg::frame_len_t len;
  } tx_desc_t;

  // one word towards the mac
  typedef struct packed {
    eth_cfg_pkg::data_word_t data;
    logic                    valid;
    logic                    last;
  } mac_tx_t;

  // sender fsm
  typedef enum logic [2:0] {
    IDLE,
    WAIT_ACK,
    HDR0,
    HDR1,
    PAYLOAD
  } sender_state_e;

endpackage

// File: rtl/udp_tx_framer.sv
`timescale 1ns/1ps

module udp_tx_framer (
  input  logic                     clk,
  input  logic                     mac_resetRR,
  input  logic                     tx_valid_i,
  input  logic                     tx_end_of_frame_i,
  input  eth_cfg_pkg::data_word_t  tx_data_i,
  input  eth_cfg_pkg::ip_addr_t    tx_dest_ip_i,
  input  eth_cfg_pkg::udp_port_t   tx_dest_port_i,
  input  logic                     full_i,
  output logic                     wr_en_o,
  output eth_cfg_pkg::data_word_t  wr_data_o,
  output logic                     commit_o,
  output tx_frame_pkg::tx_desc_t   commit_desc_o,
  output logic                     abort_o,
  output logic                     tx_overflow_o
);

  logic                    in_frame_q;
  logic                    drop_q;
  logic                    commit_q;
  logic                    overflow_q;
  eth_cfg_pkg::frame_len_t word_cnt_q;
  eth_cfg_pkg::ip_addr_t   dest_ip_q;
  eth_cfg_pkg::udp_port_t  dest_port_q;
  tx_frame_pkg::tx_desc_t  commit_desc_q;

  logic                    hit_full;
  logic                    clean_eof;
  eth_cfg_pkg::ip_addr_t   cur_ip;
  eth_cfg_pkg::udp_port_t  cur_port;

  // first beat that meets a full buffer kills the frame
  assign hit_full  = tx_valid_i && !drop_q && full_i;
  assign clean_eof = tx_valid_i && tx_end_of_frame_i && !drop_q && !full_i;

  // dest fields only count on the first beat
  assign cur_ip   = in_frame_q ? dest_ip_q : tx_dest_ip_i;
  assign cur_port = in_frame_q ? dest_port_q : tx_dest_port_i;

  assign wr_en_o       = tx_valid_i && !drop_q && !full_i;
  assign wr_data_o     = tx_data_i;
  assign abort_o       = hit_full;
  assign commit_o      = commit_q;
  assign commit_desc_o = commit_desc_q;
  assign tx_overflow_o = overflow_q;

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      in_frame_q <= 1'b0;
      drop_q     <= 1'b0;
      commit_q   <= 1'b0;
      overflow_q <= 1'b0;
      word_cnt_q <= '0;
    end else begin
      commit_q   <= clean_eof;
      overflow_q <= hit_full;
      if (tx_valid_i) begin
        if (tx_end_of_frame_i) begin
          in_frame_q <= 1'b0;
          drop_q     <= 1'b0;
          word_cnt_q <= '0;
        end else begin
          in_frame_q <= 1'b1;
          if (hit_full) begin
            drop_q <= 1'b1;
          end
          if (wr_en_o) begin
            word_cnt_q <= word_cnt_q + 16'd1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_valid_i && !in_frame_q) begin
      dest_ip_q   <= tx_dest_ip_i;
      dest_port_q <= tx_dest_port_i;
    end
    // eof beat itself is counted in len
    commit_desc_q.dest_ip   <= cur_ip;
    commit_desc_q.dest_port <= cur_port;
    commit_desc_q.len       <= word_cnt_q + 16'd1;
  end

endmodule

// File: rtl/tx_frame_buffer.sv
`timescale 1ns/1ps

module tx_frame_buffer #(
  parameter int BUF_AW       = 6,
  parameter int AFULL_MARGIN = 8
) (
  input  logic                     clk,
  input  logic                     mac_resetRR,
  input  logic                     wr_en_i,
  input  eth_cfg_pkg::data_word_t  wr_data_i,
  input  logic                     commit_i,
  input  tx_frame_pkg::tx_desc_t   commit_desc_i,
  input  logic                     abort_i,
  input  logic                     desc_pop_i,
  input  logic                     rd_en_i,
  output logic                     full_o,
  output logic                     tx_afull_o,
  output logic                     desc_valid_o,
  output tx_frame_pkg::tx_desc_t   desc_o,
  output eth_cfg_pkg::data_word_t  rd_data_o
);

  localparam int DEPTH      = 1 << BUF_AW;
  localparam int DESC_DEPTH = 4;

  // extra msb tells full from empty
  typedef logic [BUF_AW:0] ptr_t;
  typedef logic [1:0]      desc_idx_t;
  typedef logic [2:0]      desc_cnt_t;

  localparam ptr_t AFULL_LEVEL = ptr_t'(DEPTH - AFULL_MARGIN);

  eth_cfg_pkg::data_word_t mem [DEPTH];
  tx_frame_pkg::tx_desc_t  desc_mem [DESC_DEPTH];

  ptr_t      wp_q;
  ptr_t      cp_q;
  ptr_t      rp_q;
  ptr_t      cp_next;
  ptr_t      used;
  desc_idx_t dwr_q;
  desc_idx_t drd_q;
  desc_cnt_t dcnt_q;

  logic      desc_empty;
  logic      desc_full;
  logic      bypass;
  logic      push;
  logic      pop_mem;

  assign used       = wp_q - rp_q;
  assign tx_afull_o = used >= AFULL_LEVEL;

  // a commit in flight also takes a descriptor slot
  assign desc_empty = dcnt_q == 3'd0;
  assign desc_full  = (dcnt_q == 3'(DESC_DEPTH)) ||
                      (dcnt_q == 3'(DESC_DEPTH - 1) && commit_i);
  assign full_o     = (used == ptr_t'(DEPTH)) || desc_full;

  // empty fifo hands a fresh commit straight to the sender
  assign bypass       = desc_empty && commit_i;
  assign desc_valid_o = !desc_empty || commit_i;
  assign desc_o       = desc_empty ? commit_desc_i : desc_mem[drd_q];
  assign push         = commit_i && !(bypass && desc_pop_i);
  assign pop_mem      = desc_pop_i && !desc_empty;

  assign rd_data_o = mem[rp_q[BUF_AW-1:0]];

  // abort falls back to whatever is committed after this cycle
  assign cp_next = commit_i ? wp_q : cp_q;

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      wp_q   <= '0;
      cp_q   <= '0;
      rp_q   <= '0;
      dwr_q  <= '0;
      drd_q  <= '0;
      dcnt_q <= '0;
    end else begin
      cp_q <= cp_next;
      if (abort_i) begin
        wp_q <= cp_next;
      end else if (wr_en_i) begin
        wp_q <= wp_q + 1'b1;
      end
      if (rd_en_i) begin
        rp_q <= rp_q + 1'b1;
      end
      if (push) begin
        dwr_q <= dwr_q + 1'b1;
      end
      if (pop_mem) begin
        drd_q <= drd_q + 1'b1;
      end
      dcnt_q <= dcnt_q + desc_cnt_t'(push) - desc_cnt_t'(pop_mem);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wp_q[BUF_AW-1:0]] <= wr_data_i;
    end
    if (push) begin
      desc_mem[dwr_q] <= commit_desc_i;
    end
  end

endmodule

// File: rtl/mac_tx_sender.sv
`timescale 1ns/1ps

module mac_tx_sender #(
  parameter eth_cfg_pkg::ip_addr_t  LOCAL_IP   = 32'hc0a8_0a01,
  parameter eth_cfg_pkg::udp_port_t LOCAL_PORT = 16'd10000,
  parameter eth_cfg_pkg::ttl_t      TTL        = 8'd1,
  parameter int                     LED_WIDTH  = 26
) (
  input  logic                     clk,
  input  logic                     mac_resetRR,
  input  logic                     desc_valid_i,
  input  tx_frame_pkg::tx_desc_t   desc_i,
  input  eth_cfg_pkg::data_word_t  rd_data_i,
  input  logic                     mac_tx_ack_i,
  output logic                     desc_pop_o,
  output logic                     rd_en_o,
  output logic                     mac_tx_start_o,
  output tx_frame_pkg::mac_tx_t    mac_tx_o,
  output logic                     led_tx_o
);

  tx_frame_pkg::sender_state_e state_q;
  tx_frame_pkg::tx_desc_t      desc_q;
  eth_cfg_pkg::frame_len_t     remain_q;
  logic [LED_WIDTH-1:0]        tx_stretch_q;

  eth_cfg_pkg::data_word_t     hdr1;

  assign hdr1 = {LOCAL_IP, LOCAL_PORT, TTL, eth_cfg_pkg::UDP_PROTO};

  assign desc_pop_o     = (state_q == tx_frame_pkg::IDLE) && desc_valid_i;
  assign mac_tx_start_o = state_q == tx_frame_pkg::WAIT_ACK;
  assign rd_en_o        = state_q == tx_frame_pkg::PAYLOAD;
  assign led_tx_o       = tx_stretch_q[LED_WIDTH-1];

  always_comb begin
    mac_tx_o = '0;
    case (state_q)
      tx_frame_pkg::HDR0: begin
        mac_tx_o.data  = desc_q;
        mac_tx_o.valid = 1'b1;
      end
      tx_frame_pkg::HDR1: begin
        mac_tx_o.data  = hdr1;
        mac_tx_o.valid = 1'b1;
      end
      tx_frame_pkg::PAYLOAD: begin
        mac_tx_o.data  = rd_data_i;
        mac_tx_o.valid = 1'b1;
        mac_tx_o.last  = remain_q == 16'd1;
      end
      default: begin
        mac_tx_o = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state_q <= tx_frame_pkg::IDLE;
    end else begin
      case (state_q)
        tx_frame_pkg::IDLE: begin
          if (desc_valid_i) begin
            state_q <= tx_frame_pkg::WAIT_ACK;
          end
        end
        tx_frame_pkg::WAIT_ACK: begin
          if (mac_tx_ack_i) begin
            state_q <= tx_frame_pkg::HDR0;
          end
        end
        tx_frame_pkg::HDR0: state_q <= tx_frame_pkg::HDR1;
        tx_frame_pkg::HDR1: state_q <= tx_frame_pkg::PAYLOAD;
        tx_frame_pkg::PAYLOAD: begin
          if (remain_q == 16'd1) begin
            state_q <= tx_frame_pkg::IDLE;
          end
        end
        default: state_q <= tx_frame_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (desc_pop_o) begin
      desc_q <= desc_i;
    end
    // payload countdown, loaded just before the first payload word
    if (state_q == tx_frame_pkg::HDR1) begin
      remain_q <= desc_q.len;
    end else if (state_q == tx_frame_pkg::PAYLOAD) begin
      remain_q <= remain_q - 16'd1;
    end
  end

  // led stretcher, counts down while the top bit is set
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      tx_stretch_q <= '0;
    end else if (mac_tx_start_o) begin
      tx_stretch_q <= '1;
    end else if (tx_stretch_q[LED_WIDTH-1]) begin
      tx_stretch_q <= tx_stretch_q - 1'b1;
    end
  end

endmodule

// File: rtl/udp_tx_top.sv
`timescale 1ns/1ps

module udp_tx_top #(
  parameter eth_cfg_pkg::ip_addr_t  LOCAL_IP     = 32'hc0a8_0a01,
  parameter eth_cfg_pkg::udp_port_t LOCAL_PORT   = 16'd10000,
  parameter eth_cfg_pkg::ttl_t      TTL          = 8'd1,
  parameter int                     BUF_AW       = 6,
  parameter int                     AFULL_MARGIN = 8,
  parameter int                     LED_WIDTH    = 26
) (
  input  logic                     clk,
  input  logic                     mac_resetRR,
  input  logic                     tx_valid_i,
  input  logic                     tx_end_of_frame_i,
  input  eth_cfg_pkg::data_word_t  tx_data_i,
  input  eth_cfg_pkg::ip_addr_t    tx_dest_ip_i,
  input  eth_cfg_pkg::udp_port_t   tx_dest_port_i,
  output logic                     tx_overflow_o,
  output logic                     tx_afull_o,
  input  logic                     mac_tx_ack_i,
  output logic                     mac_tx_start_o,
  output tx_frame_pkg::mac_tx_t    mac_tx_o,
  output logic                     led_tx_o
);

  logic                    wr_en;
  eth_cfg_pkg::data_word_t wr_data;
  logic                    commit;
  tx_frame_pkg::tx_desc_t  commit_desc;
  logic                    abort;
  logic                    full;
  logic                    desc_valid;
  tx_frame_pkg::tx_desc_t  desc;
  logic                    desc_pop;
  logic                    rd_en;
  eth_cfg_pkg::data_word_t rd_data;

  udp_tx_framer u_framer (
    .clk               (clk),
    .mac_resetRR       (mac_resetRR),
    .tx_valid_i        (tx_valid_i),
    .tx_end_of_frame_i (tx_end_of_frame_i),
    .tx_data_i         (tx_data_i),
    .tx_dest_ip_i      (tx_dest_ip_i),
    .tx_dest_port_i    (tx_dest_port_i),
    .full_i            (full),
    .wr_en_o           (wr_en),
    .wr_data_o         (wr_data),
    .commit_o          (commit),
    .commit_desc_o     (commit_desc),
    .abort_o           (abort),
    .tx_overflow_o     (tx_overflow_o)
  );

  tx_frame_buffer #(
    .BUF_AW       (BUF_AW),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) u_buffer (
    .clk           (clk),
    .mac_resetRR   (mac_resetRR),
    .wr_en_i       (wr_en),
    .wr_data_i     (wr_data),
    .commit_i      (commit),
    .commit_desc_i (commit_desc),
    .abort_i       (abort),
    .desc_pop_i    (desc_pop),
    .rd_en_i       (rd_en),
    .full_o        (full),
    .tx_afull_o    (tx_afull_o),
    .desc_valid_o  (desc_valid),
    .desc_o        (desc),
    .rd_data_o     (rd_data)
  );

  mac_tx_sender #(
    .LOCAL_IP   (LOCAL_IP),
    .LOCAL_PORT (LOCAL_PORT),
    .TTL        (TTL),
    .LED_WIDTH  (LED_WIDTH)
  ) u_sender (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .desc_valid_i   (desc_valid),
    .desc_i         (desc),
    .rd_data_i      (rd_data),
    .mac_tx_ack_i   (mac_tx_ack_i),
    .desc_pop_o     (desc_pop),
    .rd_en_o        (rd_en),
    .mac_tx_start_o (mac_tx_start_o),
    .mac_tx_o       (mac_tx_o),
    .led_tx_o       (led_tx_o)
  );

endmodule

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// stops the run after a plain message
task automatic tb_fail(input string msg);
  $display("%s", msg);
  $display("TESTBENCH FAILED");
  $fatal(1, "%s", msg);
endtask

// one mac word against the model
task automatic check_word(input string what,
                          input eth_cfg_pkg::data_word_t got,
                          input eth_cfg_pkg::data_word_t exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s data got %h expected %h", $time, what, got, exp);
    tb_fail("word mismatch");
  end
endtask

// last marker of a mac word
task automatic check_last(input string what,
                          input logic got,
                          input logic exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s last got %b expected %b", $time, what, got, exp);
    tb_fail("last mismatch");
  end
endtask

// single status flag such as overflow or afull
task automatic check_flag(input string what,
                          input logic got,
                          input logic exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
    tb_fail("flag mismatch");
  end
endtask

`endif

// File: test/tb_udp_tx.sv
`timescale 1ns/1ps

module tb_udp_tx;

  localparam eth_cfg_pkg::ip_addr_t  LOCAL_IP   = 32'h0a00_0002;
  localparam eth_cfg_pkg::udp_port_t LOCAL_PORT = 16'd5001;
  localparam eth_cfg_pkg::ttl_t      TTL        = 8'd64;
  localparam int BUF_AW       = 6;
  localparam int AFULL_MARGIN = 8;
  localparam int LED_WIDTH    = 6;
  localparam int AFULL_WORDS  = (1 << BUF_AW) - AFULL_MARGIN;
  localparam int TIMEOUT      = 2000;

  typedef eth_cfg_pkg::data_word_t data_q_t[$];
  typedef tx_frame_pkg::mac_tx_t   word_q_t[$];

  logic                    clk;
  logic                    mac_resetRR;
  logic                    tx_valid_i;
  logic                    tx_end_of_frame_i;
  eth_cfg_pkg::data_word_t tx_data_i;
  eth_cfg_pkg::ip_addr_t   tx_dest_ip_i;
  eth_cfg_pkg::udp_port_t  tx_dest_port_i;
  logic                    tx_overflow_o;
  logic                    tx_afull_o;
  logic                    mac_tx_ack_i;
  logic                    mac_tx_start_o;
  tx_frame_pkg::mac_tx_t   mac_tx_o;
  logic                    led_tx_o;

  // expected mac words, oldest first
  word_q_t exp_q;
  int      frames_queued = 0;
  int      frames_done   = 0;
  int      ovf_cnt       = 0;
  int      word_idx      = 0;
  int      buf_words     = 0;
  int      ack_max;
  logic    ack_hold;
  logic    afull_chk;
  logic    led_chk;
  logic    write_seen    = 1'b0;

  `include "tb_checks.svh"

  udp_tx_top #(
    .LOCAL_IP     (LOCAL_IP),
    .LOCAL_PORT   (LOCAL_PORT),
    .TTL          (TTL),
    .BUF_AW       (BUF_AW),
    .AFULL_MARGIN (AFULL_MARGIN),
    .LED_WIDTH    (LED_WIDTH)
  ) dut (
    .clk               (clk),
    .mac_resetRR       (mac_resetRR),
    .tx_valid_i        (tx_valid_i),
    .tx_end_of_frame_i (tx_end_of_frame_i),
    .tx_data_i         (tx_data_i),
    .tx_dest_ip_i      (tx_dest_ip_i),
    .tx_dest_port_i    (tx_dest_port_i),
    .tx_overflow_o     (tx_overflow_o),
    .tx_afull_o        (tx_afull_o),
    .mac_tx_ack_i      (mac_tx_ack_i),
    .mac_tx_start_o    (mac_tx_start_o),
    .mac_tx_o          (mac_tx_o),
    .led_tx_o          (led_tx_o)
  );

  always #10 clk = ~clk;

  // two header words, then payload with last on the final word
  function automatic word_q_t expected_frame(input eth_cfg_pkg::ip_addr_t  ip,
                                             input eth_cfg_pkg::udp_port_t port,
                                             input data_q_t                payload);
    word_q_t               words;
    tx_frame_pkg::mac_tx_t w;
    w       = '0;
    w.valid = 1'b1;
    w.data  = {ip, port, 16'(payload.size())};
    words.push_back(w);
    w.data = {LOCAL_IP, LOCAL_PORT, TTL, 8'd17};
    words.push_back(w);
    foreach (payload[i]) begin
      w.data = payload[i];
      w.last = (i == payload.size() - 1);
      words.push_back(w);
    end
    return words;
  endfunction

  // one frame of random words with dest fields scrambled after the first beat
  task automatic send_frame(input int len, input logic keep);
    data_q_t                payload;
    word_q_t                words;
    eth_cfg_pkg::ip_addr_t  ip;
    eth_cfg_pkg::udp_port_t port;
    int                     i;
    ip   = $urandom();
    port = 16'($urandom());
    for (i = 0; i < len; i++) begin
      payload.push_back({$urandom(), $urandom()});
    end
    if (keep) begin
      words = expected_frame(ip, port, payload);
      foreach (words[j]) begin
        exp_q.push_back(words[j]);
      end
      frames_queued++;
    end
    for (i = 0; i < len; i++) begin
      @(posedge clk);
      tx_valid_i        <= 1'b1;
      tx_end_of_frame_i <= (i == len - 1);
      tx_data_i         <= payload[i];
      tx_dest_ip_i      <= (i == 0) ? ip : $urandom();
      tx_dest_port_i    <= (i == 0) ? port : 16'($urandom());
    end
    @(posedge clk);
    tx_valid_i        <= 1'b0;
    tx_end_of_frame_i <= 1'b0;
  endtask

  task automatic drain_mac();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        tb_fail("timeout: expected frames never left the MAC port");
      end
    end
  endtask

  // keeps the buffer and descriptor fifo clear of overflow
  task automatic limit_backlog(input int max_frames);
    int n;
    n = 0;
    while (frames_queued - frames_done > max_frames) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        tb_fail("timeout: queued frames are not being sent");
      end
    end
  endtask

  task automatic catch_start();
    int n;
    n = 0;
    while (mac_tx_start_o !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        tb_fail("timeout: mac_tx_start_o never rose");
      end
    end
  endtask

  task automatic led_settle();
    int n;
    n = 0;
    while (led_tx_o !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        tb_fail("timeout: led_tx_o stayed on after traffic stopped");
      end
    end
  endtask

  // mac model that acks each start after a random delay
  initial begin : mac_ack
    int delay;
    mac_tx_ack_i = 1'b0;
    forever begin
      @(negedge clk);
      if (mac_tx_start_o === 1'b1 && !ack_hold) begin
        delay = $urandom_range(ack_max, 0);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        mac_tx_ack_i <= 1'b1;
        @(posedge clk);
        mac_tx_ack_i <= 1'b0;
      end
    end
  end

  // every valid mac word against the head of the model queue
  initial begin : compare_words
    tx_frame_pkg::mac_tx_t exp;
    logic                  busy;
    busy = 1'b0;
    forever begin
      @(negedge clk);
      if (busy) begin
        check_flag("valid inside a frame", mac_tx_o.valid, 1'b1);
      end
      if (mac_tx_o.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          tb_fail("a word appeared on the MAC port with no frame expected");
        end else begin
          exp = exp_q.pop_front();
          check_word($sformatf("word %0d", word_idx), mac_tx_o.data, exp.data);
          check_last($sformatf("word %0d", word_idx), mac_tx_o.last, exp.last);
          word_idx++;
          busy = !exp.last;
          if (exp.last) begin
            frames_done++;
          end
        end
      end
    end
  end

  // overflow count, afull rule per write and led level during traffic
  always @(negedge clk) begin
    if (tx_overflow_o === 1'b1) begin
      ovf_cnt++;
    end
    if (!afull_chk) begin
      buf_words  = 0;
      write_seen = 1'b0;
    end else begin
      if (write_seen) begin
        check_flag($sformatf("afull at %0d words", buf_words), tx_afull_o,
                   buf_words >= AFULL_WORDS);
      end
      write_seen = tx_valid_i;
      if (write_seen) begin
        buf_words++;
      end
    end
    if (led_chk) begin
      check_flag("led_tx_o during traffic", led_tx_o, 1'b1);
    end
  end

  initial begin : stimulus
    int i;
    int base;
    clk               = 1'b0;
    mac_resetRR       = 1'b1;
    tx_valid_i        = 1'b0;
    tx_end_of_frame_i = 1'b0;
    tx_data_i         = '0;
    tx_dest_ip_i      = '0;
    tx_dest_port_i    = '0;
    ack_hold          = 1'b0;
    ack_max           = 0;
    afull_chk         = 1'b0;
    led_chk           = 1'b0;
    void'($urandom(32'h4be1));
    repeat (5) @(posedge clk);
    mac_resetRR <= 1'b0;
    @(negedge clk);
    check_flag("start after reset", mac_tx_start_o, 1'b0);
    check_flag("valid after reset", mac_tx_o.valid, 1'b0);
    check_flag("overflow after reset", tx_overflow_o, 1'b0);
    check_flag("afull after reset", tx_afull_o, 1'b0);
    check_flag("led after reset", led_tx_o, 1'b0);

    // single frame with start two cycles after the end of frame beat
    send_frame(4, 1'b1);
    @(negedge clk);
    check_flag("start one cycle after eof", mac_tx_start_o, 1'b0);
    @(negedge clk);
    check_flag("start two cycles after eof", mac_tx_start_o, 1'b1);
    drain_mac();

    // back-to-back traffic with random ack latency
    ack_max = 10;
    for (i = 0; i < 20; i++) begin
      limit_backlog(2);
      send_frame($urandom_range(16, 1), 1'b1);
    end
    drain_mac();
    check_flag("no overflow in normal traffic", ovf_cnt == 0, 1'b1);

    // mac stalled so the second frame runs out of room and is dropped
    ack_hold = 1'b1;
    base     = ovf_cnt;
    send_frame(10, 1'b1);
    send_frame(60, 1'b0);
    @(negedge clk);
    check_flag("one overflow pulse", (ovf_cnt - base) == 1, 1'b1);
    send_frame(5, 1'b1);
    ack_hold = 1'b0;
    drain_mac();
    check_flag("no overflow after the drop", (ovf_cnt - base) == 1, 1'b1);

    // almost-full threshold with the mac stalled
    ack_hold  = 1'b1;
    afull_chk = 1'b1;
    send_frame(30, 1'b1);
    send_frame(30, 1'b1);
    @(negedge clk);
    check_flag("afull with 60 words held", tx_afull_o, 1'b1);
    @(negedge clk);
    afull_chk = 1'b0;
    ack_hold  = 1'b0;
    drain_mac();
    check_flag("afull after drain", tx_afull_o, 1'b0);

    // led stretch over a burst, then decay
    ack_max = 0;
    send_frame(4, 1'b1);
    catch_start();
    @(negedge clk);
    check_flag("led after start", led_tx_o, 1'b1);
    led_chk = 1'b1;
    for (i = 0; i < 5; i++) begin
      limit_backlog(2);
      send_frame(4, 1'b1);
    end
    drain_mac();
    led_chk = 1'b0;
    led_settle();

    repeat (2) @(negedge clk);
    if (exp_q.size() == 0 && frames_done == frames_queued) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      tb_fail("expected frames still outstanding at the end of the run");
    end
  end

endmodule

// File: sim.f
+incdir+include
rtl/eth_cfg_pkg.sv
rtl/tx_frame_pkg.sv
rtl/udp_tx_framer.sv
rtl/tx_frame_buffer.sv
rtl/mac_tx_sender.sv
rtl/udp_tx_top.sv
test/tb_udp_tx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_tx
SEED      ?= 1
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

# pass only when the testbench printed its pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
